// File: fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Width of one instruction word in bits.
`define FETCH_WORD_W 32

// Program memory is addressed by word.
`define FETCH_ADDR_W 11

// Number of words held by the program memory.
`define FETCH_MEM_DEPTH 2048

// AND R1,R1,R1 is used as the NOP when a branch flushes the fetched word.
`define FETCH_NOP 32'h0021_0824

`endif

// File: fetch_pkg.sv
package fetch_pkg;

   // Instruction classes as seen by the next pipeline stage.
   typedef enum logic [2:0] {
      R_TYPE  = 3'd0,  // Primary opcode 0.
      I_ALU   = 3'd1,  // Immediate arithmetic and logic.
      LOAD    = 3'd2,
      STORE   = 3'd3,
      BRANCH  = 3'd4,  // BEQ and BNE.
      JUMP    = 3'd5,  // J and JAL.
      UNKNOWN = 3'd6
   } opcode_class_e;

   // The loader waits in IDLE, gathers four bytes in COLLECT, then spends one
   // cycle in WRITE while the word goes into program memory.
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      COLLECT = 2'd1,
      WRITE   = 2'd2
   } loader_state_e;

endpackage

// File: program_loader.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module program_loader (
   input  logic                       i_clock,
   input  logic                       i_soft_reset,
   input  logic                       i_load_mode,
   input  logic [7:0]                 i_load_byte,
   input  logic                       i_load_strobe,
   output logic                       o_write_strobe,
   output logic [`FETCH_ADDR_W-1:0]   o_write_address,
   output logic [`FETCH_WORD_W-1:0]   o_write_data,
   output logic                       o_load_done
);
   import fetch_pkg::*;

   loader_state_e             state;
   logic [1:0]                byte_count;  // Bytes already held in the word register.
   logic [`FETCH_WORD_W-1:0]  word_reg;

   // Bytes arrive most significant first, so each new byte shifts in at the bottom.
   always_ff @(posedge i_clock) begin
      if (i_load_mode && i_load_strobe) begin
         word_reg <= {word_reg[`FETCH_WORD_W-9:0], i_load_byte};
      end
   end

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         state           <= IDLE;
         byte_count      <= 2'd0;
         o_write_address <= '0;
      end else if (!i_load_mode) begin
         state      <= IDLE;   // Address is kept so loading can resume later.
         byte_count <= 2'd0;
      end else begin
         case (state)
            IDLE: begin
               if (i_load_strobe) begin
                  state      <= COLLECT;
                  byte_count <= 2'd1;
               end
            end
            COLLECT: begin
               if (i_load_strobe) begin
                  byte_count <= byte_count + 2'd1;
                  if (byte_count == 2'd3) begin
                     state <= WRITE;   // Fourth byte completes the word.
                  end
               end
            end
            WRITE: begin
               o_write_address <= o_write_address + 1'b1;
               // A byte may already follow in the write cycle.
               state      <= i_load_strobe ? COLLECT : IDLE;
               byte_count <= i_load_strobe ? 2'd1 : 2'd0;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // The strobe is dropped if load mode ends in the write cycle, since the
   // memory address then belongs to the fetch stage.
   assign o_write_strobe = (state == WRITE) && i_load_mode;
   assign o_load_done    = o_write_strobe;
   assign o_write_data   = word_reg;

endmodule

// File: program_memory.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

// Single-port program RAM with a registered read port.
module program_memory (
   input  logic                       i_clock,
   input  logic                       i_write_strobe,
   input  logic [`FETCH_ADDR_W-1:0]   i_address,
   input  logic [`FETCH_WORD_W-1:0]   i_write_data,
   output logic [`FETCH_WORD_W-1:0]   o_read_data
);

   logic [`FETCH_WORD_W-1:0] mem_array [0:`FETCH_MEM_DEPTH-1];

   always_ff @(posedge i_clock) begin
      if (i_write_strobe) begin
         mem_array[i_address] <= i_write_data;
      end
   end

   // The read is registered every cycle. A write to the same address returns
   // the old contents on that edge.
   always_ff @(posedge i_clock) begin
      o_read_data <= mem_array[i_address];
   end

endmodule

// File: instruction_fetch.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module instruction_fetch (
   input  logic                       i_clock,
   input  logic                       i_soft_reset,
   input  logic                       i_load_mode,
   input  logic                       i_enable_pipeline,
   input  logic                       i_bubble_hazard,
   input  logic                       i_branch_taken,
   input  logic [`FETCH_ADDR_W-1:0]   i_branch_target,
   input  logic [`FETCH_WORD_W-1:0]   i_memory_word,
   output logic [`FETCH_ADDR_W-1:0]   o_program_counter,
   output logic [`FETCH_WORD_W-1:0]   o_instruction,
   output logic [`FETCH_ADDR_W-1:0]   o_return_address,
   output logic                       o_fetch_advance
);

   logic                      advance;
   logic [`FETCH_ADDR_W-1:0]  pc_plus_one;
   logic [`FETCH_ADDR_W-1:0]  next_pc;
   logic                      flush_q;       // Branch seen on the last advancing edge.
   logic [`FETCH_ADDR_W-1:0]  return_q;      // Address after the word now in memory output.
   logic [`FETCH_WORD_W-1:0]  ir_next;

   // The pipeline moves only when enabled, free of hazards and not loading.
   assign advance     = i_enable_pipeline && !i_bubble_hazard && !i_load_mode;
   assign pc_plus_one = o_program_counter + 1'b1;
   assign next_pc     = i_branch_taken ? i_branch_target : pc_plus_one;

   // The memory registers the word at the old counter on this same edge.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_program_counter <= '0;
         o_fetch_advance   <= 1'b0;
         flush_q           <= 1'b0;
      end else begin
         o_fetch_advance <= advance;
         if (advance) begin
            o_program_counter <= next_pc;
            flush_q           <= i_branch_taken;
         end
      end
   end

   always_ff @(posedge i_clock) begin
      if (advance) begin
         return_q <= pc_plus_one;
      end
   end

   // A taken branch discards the word that was fetched behind it.
   assign ir_next = flush_q ? `FETCH_NOP : i_memory_word;

   // Half a cycle after the counter moves, the read word is stable and is
   // captured into the instruction register.
   always_ff @(negedge i_clock) begin
      if (!i_soft_reset) begin
         o_instruction    <= `FETCH_NOP;
         o_return_address <= `FETCH_ADDR_W'(1);
      end else if (o_fetch_advance) begin
         o_instruction    <= ir_next;
         o_return_address <= return_q;
      end
   end

endmodule

// File: instruction_decoder.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module instruction_decoder (
   input  logic                       i_clock,
   input  logic                       i_soft_reset,
   input  logic [`FETCH_WORD_W-1:0]   i_instruction,
   input  logic                       i_fetch_advance,
   output fetch_pkg::opcode_class_e   o_opcode_class,
   output logic [4:0]                 o_rs,
   output logic [4:0]                 o_rt,
   output logic [4:0]                 o_rd,
   output logic [`FETCH_WORD_W-1:0]   o_immediate,
   output logic                       o_decode_valid
);
   import fetch_pkg::*;

   logic [5:0]     opcode;
   opcode_class_e  class_next;
   logic [15:0]    imm_field;

   assign opcode    = i_instruction[31:26];
   assign imm_field = i_instruction[15:0];

   // Classify by the primary opcode alone.
   always_comb begin
      case (opcode) inside
         6'd0:            class_next = R_TYPE;
         6'd2, 6'd3:      class_next = JUMP;
         6'd4, 6'd5:      class_next = BRANCH;
         [6'd8:6'd15]:    class_next = I_ALU;
         [6'd32:6'd37]:   class_next = LOAD;
         [6'd40:6'd43]:   class_next = STORE;
         default:         class_next = UNKNOWN;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_decode_valid <= 1'b0;
      end else begin
         o_decode_valid <= i_fetch_advance;   // One pulse per fetched word.
      end
   end

   // Fields hold their last values while the pipeline is stalled.
   always_ff @(posedge i_clock) begin
      if (i_fetch_advance) begin
         o_opcode_class <= class_next;
         o_rs           <= i_instruction[25:21];
         o_rt           <= i_instruction[20:16];
         o_rd           <= i_instruction[15:11];
         o_immediate    <= {{(`FETCH_WORD_W-16){imm_field[15]}}, imm_field};
      end
   end

endmodule

// File: fetch_top.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_top (
   input  logic                       i_clock,
   input  logic                       i_soft_reset,
   input  logic                       i_load_mode,
   input  logic [7:0]                 i_load_byte,
   input  logic                       i_load_strobe,
   input  logic                       i_enable_pipeline,
   input  logic                       i_bubble_hazard,
   input  logic                       i_branch_taken,
   input  logic [`FETCH_ADDR_W-1:0]   i_branch_target,
   output logic [`FETCH_WORD_W-1:0]   o_instruction,
   output logic [`FETCH_ADDR_W-1:0]   o_program_counter,
   output logic [`FETCH_ADDR_W-1:0]   o_return_address,
   output fetch_pkg::opcode_class_e   o_opcode_class,
   output logic [4:0]                 o_rs,
   output logic [4:0]                 o_rt,
   output logic [4:0]                 o_rd,
   output logic [`FETCH_WORD_W-1:0]   o_immediate,
   output logic                       o_decode_valid,
   output logic                       o_load_done
);

   logic                      write_strobe;
   logic [`FETCH_ADDR_W-1:0]  write_address;
   logic [`FETCH_WORD_W-1:0]  write_data;
   logic [`FETCH_ADDR_W-1:0]  memory_address;
   logic [`FETCH_WORD_W-1:0]  memory_word;
   logic                      fetch_advance;

   // Loader owns the memory port while loading, the fetch stage otherwise.
   assign memory_address = i_load_mode ? write_address : o_program_counter;

   program_loader u_program_loader (
      .i_clock         (i_clock),
      .i_soft_reset    (i_soft_reset),
      .i_load_mode     (i_load_mode),
      .i_load_byte     (i_load_byte),
      .i_load_strobe   (i_load_strobe),
      .o_write_strobe  (write_strobe),
      .o_write_address (write_address),
      .o_write_data    (write_data),
      .o_load_done     (o_load_done)
   );

   program_memory u_program_memory (
      .i_clock        (i_clock),
      .i_write_strobe (write_strobe),
      .i_address      (memory_address),
      .i_write_data   (write_data),
      .o_read_data    (memory_word)
   );

   instruction_fetch u_instruction_fetch (
      .i_clock           (i_clock),
      .i_soft_reset      (i_soft_reset),
      .i_load_mode       (i_load_mode),
      .i_enable_pipeline (i_enable_pipeline),
      .i_bubble_hazard   (i_bubble_hazard),
      .i_branch_taken    (i_branch_taken),
      .i_branch_target   (i_branch_target),
      .i_memory_word     (memory_word),
      .o_program_counter (o_program_counter),
      .o_instruction     (o_instruction),
      .o_return_address  (o_return_address),
      .o_fetch_advance   (fetch_advance)
   );

   instruction_decoder u_instruction_decoder (
      .i_clock         (i_clock),
      .i_soft_reset    (i_soft_reset),
      .i_instruction   (o_instruction),
      .i_fetch_advance (fetch_advance),
      .o_opcode_class  (o_opcode_class),
      .o_rs            (o_rs),
      .o_rt            (o_rt),
      .o_rd            (o_rd),
      .o_immediate     (o_immediate),
      .o_decode_valid  (o_decode_valid)
   );

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module tb_fetch_top;
   import fetch_pkg::*;

   logic                      i_clock;
   logic                      i_soft_reset;
   logic                      i_load_mode;
   logic [7:0]                i_load_byte;
   logic                      i_load_strobe;
   logic                      i_enable_pipeline;
   logic                      i_bubble_hazard;
   logic                      i_branch_taken;
   logic [`FETCH_ADDR_W-1:0]  i_branch_target;
   logic [`FETCH_WORD_W-1:0]  o_instruction;
   logic [`FETCH_ADDR_W-1:0]  o_program_counter;
   logic [`FETCH_ADDR_W-1:0]  o_return_address;
   opcode_class_e             o_opcode_class;
   logic [4:0]                o_rs;
   logic [4:0]                o_rt;
   logic [4:0]                o_rd;
   logic [`FETCH_WORD_W-1:0]  o_immediate;
   logic                      o_decode_valid;
   logic                      o_load_done;

   logic [`FETCH_WORD_W-1:0]  program_words [$];   // Copy of the program from the data file.
   logic                      ctrl_enable [$];
   logic                      ctrl_bubble [$];
   logic                      ctrl_branch [$];
   logic [`FETCH_ADDR_W-1:0]  ctrl_target [$];
   int                        error_count = 0;
   int                        check_count = 0;
   int                        cycle_count = 0;
   int                        cycle_limit = 0;
   logic                      limit_ready = 1'b0;

   // Reference model of the fetch stage.
   logic [`FETCH_ADDR_W-1:0]  m_pc;
   logic [`FETCH_ADDR_W-1:0]  m_fetch_addr;   // Counter value read on the last advance.
   logic [`FETCH_ADDR_W-1:0]  m_return;
   logic [`FETCH_WORD_W-1:0]  m_instr;
   logic                      m_adv_q;
   logic                      m_flush_q;
   logic                      m_valid;
   logic                      m_decoded;      // Decoder fields hold real data.

   fetch_top DUT (.*);

   initial begin
      i_clock = 1'b0;
      forever #5 i_clock = ~i_clock;
   end

   // Ends the run if the test sequence stops making progress.
   initial begin : watchdog
      wait (limit_ready);
      while (cycle_count < cycle_limit) begin
         @(posedge i_clock);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
   end

   function automatic opcode_class_e expected_class(input logic [5:0] op);
      if (op == 6'd0) return R_TYPE;
      if (op == 6'd2 || op == 6'd3) return JUMP;
      if (op == 6'd4 || op == 6'd5) return BRANCH;
      if (op >= 6'd8 && op <= 6'd15) return I_ALU;
      if (op >= 6'd32 && op <= 6'd37) return LOAD;
      if (op >= 6'd40 && op <= 6'd43) return STORE;
      return UNKNOWN;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("error: %s is 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      end
   endtask

   task automatic read_input_file(output bit file_ok);
      int                 fd;
      string              line;
      int                 word_count;
      int                 en;
      int                 bub;
      int                 br;
      logic [31:0]        value;
      file_ok    = 1'b0;
      word_count = 0;
      fd = $fopen("fetch_input.txt", "r");
      if (fd == 0) return;
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.substr(0, 1) == "//") continue;
         if (word_count == 0) begin
            void'($sscanf(line, "%d", word_count));
         end else if (program_words.size() < word_count) begin
            void'($sscanf(line, "%h", value));
            program_words.push_back(value);
         end else if ($sscanf(line, "%d %d %d %h", en, bub, br, value) == 4) begin
            ctrl_enable.push_back(en[0]);
            ctrl_bubble.push_back(bub[0]);
            ctrl_branch.push_back(br[0]);
            ctrl_target.push_back(value[`FETCH_ADDR_W-1:0]);
         end
      end
      $fclose(fd);
      file_ok = word_count > 0 && program_words.size() == word_count && ctrl_enable.size() > 0;
   endtask

   // Sends one word as four bytes, most significant first.
   task automatic load_word(input logic [31:0] word);
      for (int b = 3; b >= 0; b--) begin
         @(posedge i_clock);
         #1;
         check_value("o_load_done", o_load_done, 0);
         i_load_byte   = word[b*8 +: 8];
         i_load_strobe = 1'b1;
      end
      @(posedge i_clock);
      #1;
      check_value("o_load_done", o_load_done, 1);   // Write cycle of the word.
      i_load_strobe = 1'b0;
   endtask

   task automatic apply_control(input int idx);
      if (idx >= 0 && idx < ctrl_enable.size()) begin
         i_enable_pipeline = ctrl_enable[idx];
         i_bubble_hazard   = ctrl_bubble[idx];
         i_branch_taken    = ctrl_branch[idx];
         i_branch_target   = ctrl_target[idx];
      end else begin
         i_enable_pipeline = 1'b0;   // Idle cycles let the decoder catch up.
         i_bubble_hazard   = 1'b0;
         i_branch_taken    = 1'b0;
         i_branch_target   = '0;
      end
   endtask

   // Moves the model across one rising edge, taking the falling edge before it first.
   task automatic step_model();
      logic adv;
      adv = i_enable_pipeline && !i_bubble_hazard && !i_load_mode;
      if (m_adv_q) begin
         m_instr  = m_flush_q ? `FETCH_NOP : program_words[m_fetch_addr];
         m_return = m_fetch_addr + 1'b1;
      end
      m_valid   = m_adv_q;
      m_decoded = m_decoded || m_adv_q;
      if (adv) begin
         m_fetch_addr = m_pc;
         m_flush_q    = i_branch_taken;
         m_pc         = i_branch_taken ? i_branch_target : m_pc + 1'b1;
      end
      m_adv_q = adv;
   endtask

   task automatic check_outputs();
      logic [15:0] imm;
      imm = m_instr[15:0];
      check_value("o_program_counter", o_program_counter, m_pc);
      check_value("o_instruction", o_instruction, m_instr);
      check_value("o_return_address", o_return_address, m_return);
      check_value("o_decode_valid", o_decode_valid, m_valid);
      check_value("o_load_done", o_load_done, 0);
      if (m_decoded) begin
         check_value("o_opcode_class", o_opcode_class, expected_class(m_instr[31:26]));
         check_value("o_rs", o_rs, m_instr[25:21]);
         check_value("o_rt", o_rt, m_instr[20:16]);
         check_value("o_rd", o_rd, m_instr[15:11]);
         check_value("o_immediate", o_immediate, {{16{imm[15]}}, imm});
      end
   endtask

   initial begin : main_sequence
      bit file_ok;
      i_soft_reset  = 1'b0;
      i_load_mode   = 1'b0;
      i_load_byte   = 8'h00;
      i_load_strobe = 1'b0;
      apply_control(-1);
      m_pc = '0;
      m_fetch_addr = '0;
      m_return = 1;
      m_instr = `FETCH_NOP;
      m_adv_q = 1'b0;
      m_flush_q = 1'b0;
      m_valid = 1'b0;
      m_decoded = 1'b0;
      read_input_file(file_ok);
      cycle_limit = 40 * 4 * program_words.size() + 10 * ctrl_enable.size() + 50;
      limit_ready = 1'b1;
      if (!file_ok) begin
         error_count++;
         $display("could not read the program and control lines from fetch_input.txt");
      end else begin
         repeat (5) @(posedge i_clock);
         #1;
         check_outputs();   // Values held by reset.
         i_soft_reset = 1'b1;
         i_load_mode  = 1'b1;
         foreach (program_words[w]) load_word(program_words[w]);
         @(posedge i_clock);
         #1;
         i_load_mode = 1'b0;
         apply_control(0);
         for (int i = 1; i <= ctrl_enable.size() + 2; i++) begin
            @(posedge i_clock);
            #1;
            step_model();
            check_outputs();
            apply_control(i);
         end
      end
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+.
fetch_pkg.sv
program_loader.sv
program_memory.sv
instruction_fetch.sv
instruction_decoder.sv
fetch_top.sv
tb_fetch_top.sv

// File: fetch_input.txt
// Word count, then one program word per line in hex.
// Control lines follow as: enable bubble branch_taken branch_target(hex).
12
00221820
2024fffb
8c450010
ac65fffc
10220003
08000008
34e68000
00210824
fc001234
1509fffe
808a7fff
0c000100
1 0 0 000
1 0 0 000
1 0 0 000
0 0 0 000
1 1 0 000
1 0 0 000
1 0 1 009
1 0 0 000
1 0 0 000
1 0 1 002
1 1 1 007
1 0 0 000
0 0 1 00a
1 0 0 000
1 0 1 006
1 0 1 000
1 0 0 000
0 0 0 000
1 0 0 000
1 0 1 005
1 0 0 000
1 0 0 000
1 0 0 000
1 0 0 000
1 0 0 000
1 0 0 000
1 0 1 000
1 0 0 000
